// File: rename_settings.svh
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// Data path width
`define RF_XLEN 32

// Architectural entries come first in the table
`define RF_ARCH_REGS 32
`define RF_PHYS_REGS 64

// Wishbone debug address width
`define DBG_ADW 8

`endif

// File: rename_pkg.sv
`include "rename_settings.svh"

package rename_pkg;

  // Index into the full table
  typedef logic [5:0] reg_idx_t;

  // One bit per rename register starting at entry 32
  typedef logic [`RF_PHYS_REGS-`RF_ARCH_REGS-1:0] free_mask_t;

  typedef struct packed {
    logic [`RF_XLEN-1:0] value;
    reg_idx_t            rrn;
    logic                valid;
    logic                tag;
  } reg_entry_t;

endpackage

// File: dbg_bus_pkg.sv
`include "rename_settings.svh"

package dbg_bus_pkg;

  typedef enum logic [`DBG_ADW-1:0] {
    DBG_CTRL   = 'h00,
    DBG_STATUS = 'h04,
    DBG_SEL    = 'h08,
    DBG_VALUE  = 'h0C,
    DBG_META   = 'h10
  } dbg_reg_e;

  typedef struct packed {
    logic [`RF_XLEN-7:0] rsvd;
    logic [5:0]          free_count;
  } status_t;

  // Selected entry fields as seen on DBG_META
  typedef struct packed {
    logic [`RF_XLEN-11:0] rsvd;
    logic                 tag;
    logic                 valid;
    logic [1:0]           pad;
    logic [5:0]           rrn;
  } meta_t;

endpackage

// File: rename_ifs.sv
`timescale 1ns/1ns
`include "rename_settings.svh"

interface register_query_if;
  import rename_pkg::*;

  logic     rename;
  reg_idx_t rd;
  logic     tag;
  // Allocated rename register or 0 when refused
  reg_idx_t rn;

  modport req (output rename, rd, tag, input rn);
  modport regs (input rename, rd, tag, output rn);
endinterface

interface register_values_if;
  import rename_pkg::*;

  reg_idx_t            src_1;
  reg_idx_t            src_2;
  logic [`RF_XLEN-1:0] data_1;
  logic                valid_1;
  logic [`RF_XLEN-1:0] data_2;
  logic                valid_2;

  modport reader (
    output src_1, src_2,
    input  data_1, valid_1, data_2, valid_2
  );
  modport regs (
    input  src_1, src_2,
    output data_1, valid_1, data_2, valid_2
  );
endinterface

interface result_bus_if;
  import rename_pkg::*;

  logic                we;
  // An arn of 0 marks a writeback and any other arn a commit
  reg_idx_t            arn;
  reg_idx_t            rrn;
  logic [`RF_XLEN-1:0] result;

  modport producer (output we, arn, rrn, result);
  modport regs (input we, arn, rrn, result);
endinterface

interface debug_read_if;
  import rename_pkg::*;

  reg_idx_t            sel;
  logic [`RF_XLEN-1:0] value;
  reg_idx_t            rrn;
  logic                valid;
  logic                tag;

  modport ctrl (output sel, input value, rrn, valid, tag);
  modport regs (input sel, output value, rrn, valid, tag);
endinterface

// File: free_list.sv
`timescale 1ns/1ns

module free_list (
  input  logic                   gsi,
  input  logic                   reset,
  output rename_pkg::reg_idx_t   alloc_idx0,
  output rename_pkg::reg_idx_t   alloc_idx1,
  input  logic                   alloc_take0,
  input  logic                   alloc_take1,
  input  rename_pkg::free_mask_t release_mask,
  output logic [5:0]             free_count
);
  import rename_pkg::*;

  free_mask_t free_q;
  free_mask_t free_d;
  free_mask_t take_mask;
  logic [4:0] first_bit;
  logic [4:0] second_bit;
  logic       first_found;
  logic       second_found;
  logic [5:0] count_d;

  // Two lowest free bits
  always_comb begin
    first_bit    = '0;
    second_bit   = '0;
    first_found  = 1'b0;
    second_found = 1'b0;
    for (int i = 0; i < $bits(free_mask_t); i++) begin
      if (free_q[i]) begin
        if (!first_found) begin
          first_found = 1'b1;
          first_bit   = 5'(i);
        end else if (!second_found) begin
          second_found = 1'b1;
          second_bit   = 5'(i);
        end
      end
    end
  end

  // Rename registers start at entry 32
  assign alloc_idx0 = first_found ? {1'b1, first_bit} : '0;
  assign alloc_idx1 = second_found ? {1'b1, second_bit} : '0;

  always_comb begin
    take_mask = '0;
    if (alloc_take0) begin
      take_mask[alloc_idx0[4:0]] = 1'b1;
    end
    if (alloc_take1) begin
      take_mask[alloc_idx1[4:0]] = 1'b1;
    end
    free_d  = (free_q & ~take_mask) | release_mask;
    count_d = '0;
    for (int i = 0; i < $bits(free_mask_t); i++) begin
      count_d = count_d + 6'(free_d[i]);
    end
  end

  always_ff @(posedge gsi) begin
    if (reset) begin
      free_q     <= '1;
      free_count <= 6'd32;
    end else begin
      free_q     <= free_d;
      free_count <= count_d;
    end
  end

endmodule

// File: register_file.sv
`timescale 1ns/1ns
`include "rename_settings.svh"

module register_file #(
  parameter int XLEN = `RF_XLEN
) (
  input  logic                   gsi,
  input  logic                   reset,
  register_query_if.regs         query [2],
  register_values_if.regs        reg_val [2],
  result_bus_if.regs             cdb [2],
  debug_read_if.regs             dbg,
  input  logic                   clear_tagged,
  input  logic                   delete_tagged,
  input  logic                   rename_enable,
  input  rename_pkg::reg_idx_t   alloc_idx0,
  input  rename_pkg::reg_idx_t   alloc_idx1,
  output logic                   alloc_take0,
  output logic                   alloc_take1,
  output rename_pkg::free_mask_t release_mask,
  input  logic [5:0]             free_count
);
  import rename_pkg::*;

  localparam int NUM_ARCH = `RF_ARCH_REGS;
  localparam int NUM_PHYS = `RF_PHYS_REGS;
  localparam int NUM_REN  = NUM_PHYS - NUM_ARCH;

  reg_entry_t      table_q [NUM_PHYS];
  reg_entry_t      table_d [NUM_PHYS];

  logic [1:0]      q_rename;
  logic [1:0]      q_tag;
  reg_idx_t        q_rd [2];
  reg_idx_t        rn_q [2];
  reg_idx_t        alloc_idx [2];
  logic [1:0]      grant;

  logic [1:0]      bus_we;
  reg_idx_t        bus_arn [2];
  reg_idx_t        bus_rrn [2];
  logic [XLEN-1:0] bus_result [2];

  free_mask_t      release_d;

  for (genvar p = 0; p < 2; p++) begin : gen_ports
    assign q_rename[p] = query[p].rename;
    assign q_rd[p]     = query[p].rd;
    assign q_tag[p]    = query[p].tag;
    assign query[p].rn = rn_q[p];

    // Operand reads see the stored table without bypass
    assign reg_val[p].data_1  = table_q[reg_val[p].src_1].value;
    assign reg_val[p].valid_1 = table_q[reg_val[p].src_1].valid;
    assign reg_val[p].data_2  = table_q[reg_val[p].src_2].value;
    assign reg_val[p].valid_2 = table_q[reg_val[p].src_2].valid;

    assign bus_we[p]     = cdb[p].we;
    assign bus_arn[p]    = cdb[p].arn;
    assign bus_rrn[p]    = cdb[p].rrn;
    assign bus_result[p] = cdb[p].result;
  end

  assign dbg.value = table_q[dbg.sel].value;
  assign dbg.rrn   = table_q[dbg.sel].rrn;
  assign dbg.valid = table_q[dbg.sel].valid;
  assign dbg.tag   = table_q[dbg.sel].tag;

  assign alloc_idx[0] = alloc_idx0;
  assign alloc_idx[1] = alloc_idx1;

  // Renaming needs two free registers and no squash
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      grant[p] = q_rename[p] && rename_enable && (free_count >= 6'd2) && !delete_tagged;
    end
  end

  assign alloc_take0  = grant[0];
  assign alloc_take1  = grant[1];
  assign release_mask = release_d;

  always_comb begin
    reg_idx_t arn;
    reg_idx_t rrn;
    reg_idx_t rd;
    reg_idx_t idx;

    table_d   = table_q;
    release_d = '0;

    if (clear_tagged) begin
      for (int i = 0; i < NUM_PHYS; i++) begin
        table_d[i].tag = 1'b0;
      end
    end

    // Port 1 is applied last so it wins on a shared entry
    for (int p = 0; p < 2; p++) begin
      arn = bus_arn[p];
      rrn = bus_rrn[p];
      if (bus_we[p]) begin
        if (arn == '0) begin
          table_d[rrn].value = bus_result[p];
          table_d[rrn].valid = 1'b1;
        end else begin
          table_d[arn].value = bus_result[p];
          table_d[arn].valid = 1'b1;
          // Keep the link if a younger rename replaced it
          if (table_q[arn].rrn == rrn) begin
            table_d[arn].rrn = '0;
            table_d[arn].tag = 1'b0;
          end
          table_d[rrn] = '0;
          if (rrn >= reg_idx_t'(NUM_ARCH)) begin
            release_d[rrn[4:0]] = 1'b1;
          end
        end
      end
    end

    if (delete_tagged) begin
      for (int i = 0; i < NUM_ARCH; i++) begin
        if (table_q[i].tag) begin
          table_d[i].valid = 1'b1;
          table_d[i].rrn   = '0;
          table_d[i].tag   = 1'b0;
        end
      end
      for (int j = 0; j < NUM_REN; j++) begin
        if (table_q[NUM_ARCH + j].tag) begin
          table_d[NUM_ARCH + j] = '0;
          release_d[j]          = 1'b1;
        end
      end
    end

    for (int p = 0; p < 2; p++) begin
      rd  = q_rd[p];
      idx = alloc_idx[p];
      if (grant[p]) begin
        table_d[rd].rrn   = idx;
        table_d[rd].valid = 1'b0;
        table_d[rd].tag   = q_tag[p];
        table_d[idx]      = '{value: '0, rrn: '0, valid: 1'b0, tag: q_tag[p]};
      end
    end
  end

  always_ff @(posedge gsi) begin
    if (reset) begin
      for (int i = 0; i < NUM_PHYS; i++) begin
        table_q[i] <= '{value: '0, rrn: '0, valid: 1'(i < NUM_ARCH), tag: 1'b0};
      end
      rn_q[0] <= '0;
      rn_q[1] <= '0;
    end else begin
      table_q <= table_d;
      for (int p = 0; p < 2; p++) begin
        rn_q[p] <= grant[p] ? alloc_idx[p] : '0;
      end
    end
  end

endmodule

// File: debug_regs.sv
`timescale 1ns/1ns
`include "rename_settings.svh"

module debug_regs (
  input  logic                gsi,
  input  logic                reset,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  logic [`DBG_ADW-1:0] wb_adr,
  input  logic [`RF_XLEN-1:0] wb_dat_w,
  output logic [`RF_XLEN-1:0] wb_dat_r,
  output logic                wb_ack,
  debug_read_if.ctrl          dbg,
  input  logic [5:0]          free_count,
  output logic                rename_enable
);
  import rename_pkg::*;
  import dbg_bus_pkg::*;

  logic                req;
  logic                accept;
  logic                done_q;
  logic                enable_q;
  reg_idx_t            sel_q;
  status_t             status;
  meta_t               meta;
  logic [`RF_XLEN-1:0] rd_data;

  assign req = wb_cyc && wb_stb;
  // No second ack while stb stays high
  assign accept = req && !wb_ack && !done_q;

  always_ff @(posedge gsi) begin
    if (reset) begin
      wb_ack   <= 1'b0;
      done_q   <= 1'b0;
      enable_q <= 1'b1;
      sel_q    <= '0;
    end else begin
      wb_ack <= accept;
      done_q <= req && (done_q || wb_ack);
      if (accept && wb_we) begin
        case (dbg_reg_e'(wb_adr))
          DBG_CTRL: enable_q <= wb_dat_w[0];
          DBG_SEL:  sel_q <= wb_dat_w[5:0];
          default:  ;
        endcase
      end
    end
  end

  always_comb begin
    status            = '0;
    status.free_count = free_count;
    meta              = '0;
    meta.rrn          = dbg.rrn;
    meta.valid        = dbg.valid;
    meta.tag          = dbg.tag;
    case (dbg_reg_e'(wb_adr))
      DBG_CTRL:   rd_data = {{(`RF_XLEN-1){1'b0}}, enable_q};
      DBG_STATUS: rd_data = status;
      DBG_SEL:    rd_data = {{(`RF_XLEN-6){1'b0}}, sel_q};
      DBG_VALUE:  rd_data = dbg.value;
      DBG_META:   rd_data = meta;
      default:    rd_data = '0;
    endcase
  end

  // Read data lands together with the ack
  always_ff @(posedge gsi) begin
    if (accept) begin
      wb_dat_r <= rd_data;
    end
  end

  assign dbg.sel       = sel_q;
  assign rename_enable = enable_q;

endmodule

// File: rename_unit_top.sv
`timescale 1ns/1ns
`include "rename_settings.svh"

module rename_unit_top (
  input  logic                 gsi,
  input  logic                 reset,
  // Rename ports
  input  logic                 q0_rename,
  input  rename_pkg::reg_idx_t q0_rd,
  input  logic                 q0_tag,
  output rename_pkg::reg_idx_t q0_rn,
  input  logic                 q1_rename,
  input  rename_pkg::reg_idx_t q1_rd,
  input  logic                 q1_tag,
  output rename_pkg::reg_idx_t q1_rn,
  // Two operand reads per issue slot
  input  rename_pkg::reg_idx_t r0_src_1,
  input  rename_pkg::reg_idx_t r0_src_2,
  output logic [`RF_XLEN-1:0]  r0_data_1,
  output logic                 r0_valid_1,
  output logic [`RF_XLEN-1:0]  r0_data_2,
  output logic                 r0_valid_2,
  input  rename_pkg::reg_idx_t r1_src_1,
  input  rename_pkg::reg_idx_t r1_src_2,
  output logic [`RF_XLEN-1:0]  r1_data_1,
  output logic                 r1_valid_1,
  output logic [`RF_XLEN-1:0]  r1_data_2,
  output logic                 r1_valid_2,
  // Result buses
  input  logic                 cdb0_we,
  input  rename_pkg::reg_idx_t cdb0_arn,
  input  rename_pkg::reg_idx_t cdb0_rrn,
  input  logic [`RF_XLEN-1:0]  cdb0_result,
  input  logic                 cdb1_we,
  input  rename_pkg::reg_idx_t cdb1_arn,
  input  rename_pkg::reg_idx_t cdb1_rrn,
  input  logic [`RF_XLEN-1:0]  cdb1_result,
  input  logic                 clear_tagged,
  input  logic                 delete_tagged,
  // Wishbone debug slave
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  logic [`DBG_ADW-1:0]  wb_adr,
  input  logic [`RF_XLEN-1:0]  wb_dat_w,
  output logic [`RF_XLEN-1:0]  wb_dat_r,
  output logic                 wb_ack
);
  import rename_pkg::*;

  register_query_if  query [2] ();
  register_values_if reg_val [2] ();
  result_bus_if      cdb [2] ();
  debug_read_if      dbg_rd ();

  reg_idx_t   alloc_idx0;
  reg_idx_t   alloc_idx1;
  logic       alloc_take0;
  logic       alloc_take1;
  free_mask_t release_mask;
  logic [5:0] free_count;
  logic       rename_enable;

  assign query[0].rename = q0_rename;
  assign query[0].rd     = q0_rd;
  assign query[0].tag    = q0_tag;
  assign q0_rn           = query[0].rn;
  assign query[1].rename = q1_rename;
  assign query[1].rd     = q1_rd;
  assign query[1].tag    = q1_tag;
  assign q1_rn           = query[1].rn;

  assign reg_val[0].src_1 = r0_src_1;
  assign reg_val[0].src_2 = r0_src_2;
  assign r0_data_1        = reg_val[0].data_1;
  assign r0_valid_1       = reg_val[0].valid_1;
  assign r0_data_2        = reg_val[0].data_2;
  assign r0_valid_2       = reg_val[0].valid_2;
  assign reg_val[1].src_1 = r1_src_1;
  assign reg_val[1].src_2 = r1_src_2;
  assign r1_data_1        = reg_val[1].data_1;
  assign r1_valid_1       = reg_val[1].valid_1;
  assign r1_data_2        = reg_val[1].data_2;
  assign r1_valid_2       = reg_val[1].valid_2;

  assign cdb[0].we     = cdb0_we;
  assign cdb[0].arn    = cdb0_arn;
  assign cdb[0].rrn    = cdb0_rrn;
  assign cdb[0].result = cdb0_result;
  assign cdb[1].we     = cdb1_we;
  assign cdb[1].arn    = cdb1_arn;
  assign cdb[1].rrn    = cdb1_rrn;
  assign cdb[1].result = cdb1_result;

  free_list i_free_list (
    .gsi          (gsi),
    .reset        (reset),
    .alloc_idx0   (alloc_idx0),
    .alloc_idx1   (alloc_idx1),
    .alloc_take0  (alloc_take0),
    .alloc_take1  (alloc_take1),
    .release_mask (release_mask),
    .free_count   (free_count)
  );

  register_file #(
    .XLEN (`RF_XLEN)
  ) i_register_file (
    .gsi           (gsi),
    .reset         (reset),
    .query         (query),
    .reg_val       (reg_val),
    .cdb           (cdb),
    .dbg           (dbg_rd),
    .clear_tagged  (clear_tagged),
    .delete_tagged (delete_tagged),
    .rename_enable (rename_enable),
    .alloc_idx0    (alloc_idx0),
    .alloc_idx1    (alloc_idx1),
    .alloc_take0   (alloc_take0),
    .alloc_take1   (alloc_take1),
    .release_mask  (release_mask),
    .free_count    (free_count)
  );

  debug_regs i_debug_regs (
    .gsi           (gsi),
    .reset         (reset),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .dbg           (dbg_rd),
    .free_count    (free_count),
    .rename_enable (rename_enable)
  );

endmodule

// File: tb_rename_unit.sv
`timescale 1ns/1ns
`include "rename_settings.svh"

module tb_rename_unit;
  import dbg_bus_pkg::*;

  localparam int OP_IDLE   = 0;
  localparam int OP_RENAME = 1;
  localparam int OP_RESULT = 2;
  localparam int OP_CLEAR  = 3;
  localparam int OP_DELETE = 4;
  localparam int OP_WR     = 5;
  localparam int OP_RD     = 6;
  localparam int OP_PEEK   = 7;
  localparam int OP_SCAN   = 8;

  localparam int ADR_CTRL   = int'(DBG_CTRL);
  localparam int ADR_STATUS = int'(DBG_STATUS);
  localparam int ADR_SEL    = int'(DBG_SEL);
  localparam int ADR_VALUE  = int'(DBG_VALUE);
  localparam int ADR_META   = int'(DBG_META);

  // op, port or rename tag, x, y, expected (-1 takes the value from the reference model)
  typedef struct {
    int op;
    int p;
    int x;
    int y;
    int e;
  } step_t;

  logic gsi, reset;
  logic q0_rename, q0_tag, q1_rename, q1_tag;
  logic [5:0] q0_rd, q1_rd, q0_rn, q1_rn;
  logic [5:0] r0_src_1, r0_src_2, r1_src_1, r1_src_2;
  logic [31:0] r0_data_1, r0_data_2, r1_data_1, r1_data_2;
  logic r0_valid_1, r0_valid_2, r1_valid_1, r1_valid_2;
  logic cdb0_we, cdb1_we;
  logic [5:0] cdb0_arn, cdb0_rrn, cdb1_arn, cdb1_rrn;
  logic [31:0] cdb0_result, cdb1_result;
  logic clear_tagged, delete_tagged;
  logic wb_cyc, wb_stb, wb_we, wb_ack;
  logic [7:0] wb_adr;
  logic [31:0] wb_dat_w, wb_dat_r;

  // Reference model
  logic [31:0] ref_val [64];
  int ref_rrn [64];
  bit ref_valid [64];
  bit ref_tag [64];
  bit ref_free [32];
  bit ref_en;
  int ref_sel;
  int seed = 55;
  step_t steps [$];

  rename_unit_top i_dut (.*);

  initial gsi = 1'b0;
  always #20 gsi = ~gsi;

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  function automatic int free_cnt();
    int n;
    n = 0;
    for (int i = 0; i < 32; i++) n += int'(ref_free[i]);
    return n;
  endfunction

  function automatic void clear_entry(int i, bit tag);
    ref_val[i] = '0;
    ref_rrn[i] = 0;
    ref_valid[i] = 1'b0;
    ref_tag[i] = tag;
  endfunction

  task automatic next_cycle();
    @(posedge gsi);
    #2;
  endtask

  task automatic do_rename(input int rd0, input int rd1, input bit tag);
    int f [2];
    int k;
    int exp0, exp1;
    bit ok;
    f[0] = 0;
    f[1] = 0;
    k = 0;
    for (int i = 0; i < 32; i++) begin
      if (ref_free[i] && k < 2) begin
        f[k] = 32 + i;
        k++;
      end
    end
    ok = ref_en && free_cnt() >= 2;
    exp0 = (rd0 != 0 && ok) ? f[0] : 0;
    exp1 = (rd1 != 0 && ok) ? f[1] : 0;
    q0_rename = rd0 != 0;
    q0_rd = 6'(rd0);
    q0_tag = tag;
    q1_rename = rd1 != 0;
    q1_rd = 6'(rd1);
    q1_tag = tag;
    next_cycle();
    q0_rename = 1'b0;
    q1_rename = 1'b0;
    check_val("q0_rn", 32'(q0_rn), exp0);
    check_val("q1_rn", 32'(q1_rn), exp1);
    if (exp0 != 0) begin
      ref_rrn[rd0] = exp0;
      ref_valid[rd0] = 1'b0;
      ref_tag[rd0] = tag;
      clear_entry(exp0, tag);
      ref_free[exp0 - 32] = 1'b0;
    end
    if (exp1 != 0) begin
      ref_rrn[rd1] = exp1;
      ref_valid[rd1] = 1'b0;
      ref_tag[rd1] = tag;
      clear_entry(exp1, tag);
      ref_free[exp1 - 32] = 1'b0;
    end
  endtask

  task automatic do_result(input int p, input int arn, input int rrn);
    logic [31:0] v;
    v = $random(seed);
    if (p == 0) begin
      {cdb0_we, cdb0_arn, cdb0_rrn, cdb0_result} = {1'b1, 6'(arn), 6'(rrn), v};
    end else begin
      {cdb1_we, cdb1_arn, cdb1_rrn, cdb1_result} = {1'b1, 6'(arn), 6'(rrn), v};
    end
    next_cycle();
    cdb0_we = 1'b0;
    cdb1_we = 1'b0;
    if (arn == 0) begin
      ref_val[rrn] = v;
      ref_valid[rrn] = 1'b1;
    end else begin
      ref_val[arn] = v;
      ref_valid[arn] = 1'b1;
      if (ref_rrn[arn] == rrn) begin
        ref_rrn[arn] = 0;
        ref_tag[arn] = 1'b0;
      end
      clear_entry(rrn, 1'b0);
      if (rrn >= 32) ref_free[rrn - 32] = 1'b1;
    end
  endtask

  task automatic wb_xfer(input bit we, input int adr, input logic [31:0] wdat,
                         output logic [31:0] rdat);
    int n;
    {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w} = {1'b1, 1'b1, we, 8'(adr), wdat};
    n = 0;
    next_cycle();
    while (!wb_ack) begin
      n++;
      if (n >= 20) begin
        $display("Wishbone ack did not arrive within 20 cycles");
        $display("Test FAILED");
        $fatal(1);
      end
      next_cycle();
    end
    rdat = wb_dat_r;
    // Ack stays low while the strobe is held one more cycle
    next_cycle();
    check_val("wb_ack", 32'(wb_ack), 32'd0);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    next_cycle();
  endtask

  task automatic dbg_read(input int adr, input int e);
    logic [31:0] exp, got;
    case (adr)
      ADR_CTRL:   exp = 32'(ref_en);
      ADR_STATUS: exp = free_cnt();
      ADR_SEL:    exp = ref_sel;
      ADR_VALUE:  exp = ref_val[ref_sel];
      ADR_META: begin
        exp = (32'(ref_tag[ref_sel]) << 9) | (32'(ref_valid[ref_sel]) << 8) | ref_rrn[ref_sel];
      end
      default:    exp = '0;
    endcase
    if (e >= 0) exp = e;
    wb_xfer(1'b0, adr, '0, got);
    check_val("wb_dat_r", got, exp);
  endtask

  task automatic dbg_write(input int adr, input int d);
    logic [31:0] unused;
    wb_xfer(1'b1, adr, d, unused);
    if (adr == ADR_CTRL) ref_en = d[0];
    if (adr == ADR_SEL) ref_sel = int'(d[5:0]);
  endtask

  task automatic scan_reads();
    for (int i = 0; i < 64; i += 4) begin
      {r0_src_1, r0_src_2, r1_src_1, r1_src_2} = {6'(i), 6'(i + 1), 6'(i + 2), 6'(i + 3)};
      next_cycle();
      check_val("r0_data_1", r0_data_1, ref_val[i]);
      check_val("r0_valid_1", 32'(r0_valid_1), 32'(ref_valid[i]));
      check_val("r0_data_2", r0_data_2, ref_val[i + 1]);
      check_val("r0_valid_2", 32'(r0_valid_2), 32'(ref_valid[i + 1]));
      check_val("r1_data_1", r1_data_1, ref_val[i + 2]);
      check_val("r1_valid_1", 32'(r1_valid_1), 32'(ref_valid[i + 2]));
      check_val("r1_data_2", r1_data_2, ref_val[i + 3]);
      check_val("r1_valid_2", 32'(r1_valid_2), 32'(ref_valid[i + 3]));
    end
  endtask

  task automatic tag_action(input bit del);
    clear_tagged = !del;
    delete_tagged = del;
    next_cycle();
    clear_tagged = 1'b0;
    delete_tagged = 1'b0;
    for (int i = 0; i < 64; i++) begin
      if (ref_tag[i] && del) begin
        if (i < 32) begin
          ref_valid[i] = 1'b1;
          ref_rrn[i] = 0;
          ref_tag[i] = 1'b0;
        end else begin
          clear_entry(i, 1'b0);
          ref_free[i - 32] = 1'b1;
        end
      end
      ref_tag[i] = 1'b0;
    end
  endtask

  task automatic add(input int op, input int p, input int x, input int y, input int e);
    steps.push_back('{op, p, x, y, e});
  endtask

  initial begin
    step_t s;
    {q0_rename, q0_tag, q1_rename, q1_tag, q0_rd, q1_rd} = '0;
    {r0_src_1, r0_src_2, r1_src_1, r1_src_2} = '0;
    {cdb0_we, cdb0_arn, cdb0_rrn, cdb0_result} = '0;
    {cdb1_we, cdb1_arn, cdb1_rrn, cdb1_result} = '0;
    {clear_tagged, delete_tagged, wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w} = '0;
    for (int i = 0; i < 64; i++) begin
      clear_entry(i, 1'b0);
      ref_valid[i] = i < 32;
    end
    for (int i = 0; i < 32; i++) ref_free[i] = 1'b1;
    ref_en = 1'b1;
    ref_sel = 0;

    add(OP_RD, 0, ADR_STATUS, 0, 32);
    add(OP_SCAN, 0, 0, 0, -1);
    add(OP_RENAME, 0, 5, 6, -1);
    add(OP_SCAN, 0, 0, 0, -1);
    add(OP_RESULT, 0, 0, 32, -1);
    add(OP_RESULT, 1, 0, 33, -1);
    add(OP_SCAN, 0, 0, 0, -1);
    add(OP_RESULT, 0, 5, 32, -1);
    add(OP_RESULT, 1, 6, 33, -1);
    add(OP_RD, 0, ADR_STATUS, 0, 32);
    // Younger rename of r7 outlives the older commit
    add(OP_RENAME, 0, 7, 0, -1);
    add(OP_RESULT, 0, 0, 32, -1);
    add(OP_RENAME, 0, 7, 0, -1);
    add(OP_RESULT, 1, 7, 32, -1);
    add(OP_WR, 0, ADR_SEL, 7, -1);
    add(OP_RD, 0, ADR_META, 0, -1);
    add(OP_RESULT, 0, 0, 33, -1);
    add(OP_RESULT, 0, 7, 33, -1);
    add(OP_SCAN, 0, 0, 0, -1);
    add(OP_WR, 0, ADR_CTRL, 0, -1);
    add(OP_RENAME, 0, 8, 9, -1);
    add(OP_RD, 0, ADR_STATUS, 0, 32);
    add(OP_WR, 0, ADR_CTRL, 1, -1);
    for (int k = 0; k < 15; k++) add(OP_RENAME, 1, 2 * k + 1, 2 * k + 2, -1);
    add(OP_RENAME, 1, 31, 0, -1);
    add(OP_RENAME, 1, 3, 4, -1);
    add(OP_RD, 0, ADR_STATUS, 0, 1);
    add(OP_DELETE, 0, 0, 0, -1);
    add(OP_RD, 0, ADR_STATUS, 0, 32);
    add(OP_SCAN, 0, 0, 0, -1);
    add(OP_RENAME, 1, 10, 11, -1);
    add(OP_CLEAR, 0, 0, 0, -1);
    add(OP_WR, 0, ADR_SEL, 10, -1);
    add(OP_RD, 0, ADR_META, 0, 32);
    add(OP_IDLE, 0, 0, 0, -1);
    for (int k = 0; k < 6; k++) add(OP_PEEK, 0, 0, 0, -1);

    reset = 1'b1;
    repeat (8) @(posedge gsi);
    #2;
    reset = 1'b0;
    next_cycle();
    check_val("wb_ack", 32'(wb_ack), 32'd0);
    check_val("q0_rn", 32'(q0_rn), 32'd0);
    check_val("q1_rn", 32'(q1_rn), 32'd0);

    foreach (steps[i]) begin
      s = steps[i];
      case (s.op)
        OP_RENAME: do_rename(s.x, s.y, s.p[0]);
        OP_RESULT: do_result(s.p, s.x, s.y);
        OP_CLEAR:  tag_action(1'b0);
        OP_DELETE: tag_action(1'b1);
        OP_WR:     dbg_write(s.x, s.y);
        OP_RD:     dbg_read(s.x, s.e);
        OP_SCAN:   scan_reads();
        OP_PEEK: begin
          dbg_write(ADR_SEL, $unsigned($random(seed)) % 64);
          dbg_read(ADR_VALUE, -1);
          dbg_read(ADR_META, -1);
        end
        default:   next_cycle();
      endcase
    end
    $display("Test OK");
    $finish;
  end

endmodule

// File: src.f
+incdir+.
rename_pkg.sv
dbg_bus_pkg.sv
rename_ifs.sv
free_list.sv
register_file.sv
debug_regs.sv
rename_unit_top.sv
tb_rename_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rename unit testbench with Verilator
verilator --binary --timing --top-module tb_rename_unit -f src.f -o sim_rename \
  || { echo "Build failed"; exit 1; }
./obj_dir/sim_rename > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log && exit 0 || exit 1
